//--- rtl/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit import cpuPkg::*; (
    input  word_t       srcA,
    input  word_t       srcB,
    input  aluOp_t      op,
    input  logic [4:0]  shamt,
    output word_t       result,
    output logic        zero
);
    always_comb begin
        case (op)
            ALU_ADD:  result = srcA + srcB;
            ALU_OR:   result = srcA | srcB;
            ALU_LUI:  result = srcB << 16;
            ALU_SRL:  result = srcB >> shamt; // logical, zero fill
            ALU_SLTU: result = (srcA < srcB) ? 32'd1 : 32'd0;
            ALU_SUBU: result = srcA - srcB;
            default:  result = srcA + srcB;
        endcase
    end

    // branches compare through SUBU
    assign zero = (result == '0);
endmodule

`default_nettype wire

//--- rtl/cpuCore.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCore import cpuPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t regAddr,   // debug read index, 0 gives pc
    output word_t    regData,
    output word_t    imAddr,
    input  word_t    imData,
    output word_t    dmAddr,
    output logic     dmWe,
    output word_t    dmWData,
    input  word_t    dmRData
);
    ctrlIf ctrl ();

    word_t    pc;
    word_t    signImm;
    word_t    rsData;
    word_t    rtData;
    word_t    dbgData;
    word_t    aluB;
    word_t    aluResult;
    word_t    wbData;
    regAddr_t wrAddr;
    logic     aluZero;

    assign imAddr  = pc;
    assign signImm = {{16{imData[15]}}, imData[15:0]};

    assign wrAddr = ctrl.regDst ? imData[15:11] : imData[20:16];
    assign aluB   = ctrl.aluSrc ? signImm : rtData;
    assign wbData = ctrl.memToReg ? dmRData : aluResult;

    // data memory side
    assign dmAddr  = aluResult;
    assign dmWe    = ctrl.memWrite;
    assign dmWData = rtData;

    assign regData = (regAddr != '0) ? dbgData : pc;

    instrDecoder i_decoder (
        .opcode  (imData[31:26]),
        .funct   (imData[5:0]),
        .aluZero (aluZero),
        .ctrl    (ctrl)
    );

    regFile i_regFile (
        .clk     (clk),
        .rdAddrA (imData[25:21]),
        .rdAddrB (imData[20:16]),
        .dbgAddr (regAddr),
        .wrAddr  (wrAddr),
        .rdDataA (rsData),
        .rdDataB (rtData),
        .dbgData (dbgData),
        .wrData  (wbData),
        .wrEn    (ctrl.regWrite)
    );

    aluUnit i_alu (
        .srcA   (rsData),
        .srcB   (aluB),
        .op     (ctrl.aluOp),
        .shamt  (imData[10:6]),
        .result (aluResult),
        .zero   (aluZero)
    );

    progCounter i_pc (
        .clk          (clk),
        .rst          (rst),
        .branchTaken  (ctrl.pcSrc),
        .branchOffset (signImm),
        .pc           (pc)
    );
endmodule

`default_nettype wire

//--- rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [31:0] word_t;    // data or address word
    typedef logic [4:0]  regAddr_t; // register index
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_OR   = 3'd1,
        ALU_LUI  = 3'd2,
        ALU_SRL  = 3'd3,
        ALU_SLTU = 3'd4,
        ALU_SUBU = 3'd5
    } aluOp_t;

    // primary opcodes
    localparam opcode_t C_SPEC  = 6'b000000; // R-type, decoded by funct
    localparam opcode_t C_ADDIU = 6'b001001;
    localparam opcode_t C_LUI   = 6'b001111;
    localparam opcode_t C_LW    = 6'b100011;
    localparam opcode_t C_SW    = 6'b101011;
    localparam opcode_t C_BEQ   = 6'b000100;
    localparam opcode_t C_BNE   = 6'b000101;

    // R-type function codes
    localparam funct_t F_ADDU = 6'b100001;
    localparam funct_t F_OR   = 6'b100101;
    localparam funct_t F_SRL  = 6'b000010;
    localparam funct_t F_SLTU = 6'b101011;
    localparam funct_t F_SUBU = 6'b100011;

    // memory sizes in words
    localparam int IM_DEPTH = 64;
    localparam int DM_DEPTH = 64;
    localparam int IM_AW    = $clog2(IM_DEPTH);
    localparam int DM_AW    = $clog2(DM_DEPTH);

endpackage

`default_nettype wire

//--- rtl/cpuSystem.sv
`timescale 1ns/10ps
`default_nettype none

module cpuSystem import cpuPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     imLoadWe,
    input  word_t    imLoadAddr,
    input  word_t    imLoadData,
    input  regAddr_t regAddr,
    output word_t    regData
);
    word_t imAddr;
    word_t imData;
    word_t dmAddr;
    word_t dmWData;
    word_t dmRData;
    logic  dmWe;

    cpuCore i_core (
        .clk     (clk),
        .rst     (rst),
        .regAddr (regAddr),
        .regData (regData),
        .imAddr  (imAddr),
        .imData  (imData),
        .dmAddr  (dmAddr),
        .dmWe    (dmWe),
        .dmWData (dmWData),
        .dmRData (dmRData)
    );

    instrMem i_instrMem (
        .clk       (clk),
        .fetchAddr (imAddr),
        .fetchData (imData),
        .loadWe    (imLoadWe),
        .loadAddr  (imLoadAddr),
        .loadData  (imLoadData)
    );

    dataMem i_dataMem (
        .clk   (clk),
        .addr  (dmAddr),
        .we    (dmWe),
        .wData (dmWData),
        .rData (dmRData)
    );
endmodule

`default_nettype wire

//--- rtl/ctrlIf.sv
`timescale 1ns/10ps
`default_nettype none

// decoded control levels, decoder to datapath
interface ctrlIf import cpuPkg::*; ();
    logic   regDst;   // write to rd instead of rt
    logic   regWrite;
    logic   aluSrc;   // second operand is the immediate
    aluOp_t aluOp;
    logic   memWrite;
    logic   memToReg; // writeback from data memory
    logic   pcSrc;    // branch taken

    modport decoder (
        output regDst, regWrite, aluSrc, aluOp, memWrite, memToReg, pcSrc
    );

    modport datapath (
        input regDst, regWrite, aluSrc, aluOp, memWrite, memToReg, pcSrc
    );
endinterface

`default_nettype wire

//--- rtl/dataMem.sv
`timescale 1ns/10ps
`default_nettype none

module dataMem import cpuPkg::*; (
    input  logic  clk,
    input  word_t addr,     // word address
    input  logic  we,
    input  word_t wData,
    output word_t rData
);
    word_t mem [DM_DEPTH];

    // low bits only, wraps above DM_DEPTH
    assign rData = mem[addr[DM_AW-1:0]];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[DM_AW-1:0]] <= wData;
        end
    end
endmodule

`default_nettype wire

//--- rtl/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder import cpuPkg::*; (
    input  opcode_t       opcode,
    input  funct_t        funct,
    input  logic          aluZero,
    ctrlIf.decoder        ctrl
);
    logic branch;
    logic condZero; // taken on zero (BEQ) or on nonzero (BNE)

    assign ctrl.pcSrc = branch & (aluZero == condZero);

    always_comb begin
        // defaults give a no-op
        ctrl.regDst   = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.aluOp    = ALU_ADD;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        branch        = 1'b0;
        condZero      = 1'b0;

        case (opcode)
            C_SPEC: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    F_ADDU:  ctrl.aluOp = ALU_ADD;
                    F_OR:    ctrl.aluOp = ALU_OR;
                    F_SRL:   ctrl.aluOp = ALU_SRL;
                    F_SLTU:  ctrl.aluOp = ALU_SLTU;
                    F_SUBU:  ctrl.aluOp = ALU_SUBU;
                    default: ctrl.regWrite = 1'b0; // unknown funct
                endcase
            end
            C_ADDIU: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            C_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_LUI;
            end
            C_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            C_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1; // address = rs + imm
            end
            C_BEQ: begin
                branch      = 1'b1;
                condZero    = 1'b1;
                ctrl.aluOp  = ALU_SUBU;
            end
            C_BNE: begin
                branch      = 1'b1;
                ctrl.aluOp  = ALU_SUBU;
            end
            default: ;
        endcase
    end
endmodule

`default_nettype wire

//--- rtl/instrMem.sv
`timescale 1ns/10ps
`default_nettype none

module instrMem import cpuPkg::*; (
    input  logic  clk,
    input  word_t fetchAddr,
    output word_t fetchData,
    input  logic  loadWe,   // program load, used under reset
    input  word_t loadAddr,
    input  word_t loadData
);
    word_t mem [IM_DEPTH];

    assign fetchData = mem[fetchAddr[IM_AW-1:0]]; // upper bits ignored

    always_ff @(posedge clk) begin
        if (loadWe) begin
            mem[loadAddr[IM_AW-1:0]] <= loadData;
        end
    end
endmodule

`default_nettype wire

//--- rtl/progCounter.sv
`timescale 1ns/10ps
`default_nettype none

module progCounter import cpuPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  branchTaken,
    input  word_t branchOffset,
    output word_t pc
);
    word_t pcNext;

    // word indexed, so sequential step is +1
    assign pcNext = branchTaken ? (pc + 32'd1 + branchOffset) : (pc + 32'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end
endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  logic     clk,
    input  regAddr_t rdAddrA,
    input  regAddr_t rdAddrB,
    input  regAddr_t dbgAddr,
    input  regAddr_t wrAddr,
    output word_t    rdDataA,
    output word_t    rdDataB,
    output word_t    dbgData,
    input  word_t    wrData,
    input  logic     wrEn
);
    word_t regs [32];

    // r0 is hardwired to zero on every read port
    assign rdDataA = (rdAddrA != '0) ? regs[rdAddrA] : '0;
    assign rdDataB = (rdAddrB != '0) ? regs[rdAddrB] : '0;
    assign dbgData = (dbgAddr != '0) ? regs[dbgAddr] : '0;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            regs[wrAddr] <= wrData; // r0 may be written, never read back
        end
    end
endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module cpuTb -f sources.f -o cpuTbSim

./obj_dir/cpuTbSim | tee sim.log

if grep -q "Testbench passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- sources.f
+incdir+tb
rtl/cpuPkg.sv
rtl/ctrlIf.sv
rtl/instrDecoder.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/progCounter.sv
rtl/cpuCore.sv
rtl/instrMem.sv
rtl/dataMem.sv
rtl/cpuSystem.sv
tb/cpuTb.sv

//--- tb/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// architectural state of the reference model
word_t mRegs [32];
word_t mMem  [DM_DEPTH];
word_t mPc;

task automatic modelClear();
    for (int i = 0; i < 32; i++) mRegs[i] = '0;
    for (int i = 0; i < DM_DEPTH; i++) mMem[i] = '0;
    mPc = '0;
endtask

// one instruction; under reset the writes still land but pc goes back to 0
task automatic modelStep(input word_t instr, input bit inReset);
    word_t    a;
    word_t    b;
    word_t    imm;
    word_t    res;
    word_t    addr;
    word_t    nextPc;
    regAddr_t dst;
    bit       wr;
    a      = mRegs[instr[25:21]];
    b      = mRegs[instr[20:16]];
    imm    = {{16{instr[15]}}, instr[15:0]};
    addr   = a + imm;
    nextPc = mPc + 32'd1;
    dst    = instr[20:16];
    wr     = 1'b0;
    res    = '0;
    case (instr[31:26])
        C_SPEC: begin
            dst = instr[15:11];
            wr  = 1'b1;
            case (instr[5:0])
                F_ADDU:  res = a + b;
                F_SUBU:  res = a - b;
                F_OR:    res = a | b;
                F_SRL:   res = b >> instr[10:6];
                F_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
                default: wr = 1'b0;
            endcase
        end
        C_ADDIU: begin
            wr  = 1'b1;
            res = a + imm;
        end
        C_LUI: begin
            wr  = 1'b1;
            res = {instr[15:0], 16'h0000};
        end
        C_LW: begin
            wr  = 1'b1;
            res = mMem[addr[DM_AW-1:0]];
        end
        C_SW:  mMem[addr[DM_AW-1:0]] = b;
        C_BEQ: if (a == b) nextPc = mPc + 32'd1 + imm;
        C_BNE: if (a != b) nextPc = mPc + 32'd1 + imm;
        default: ;
    endcase
    if (wr && dst != '0) mRegs[dst] = res; // r0 never changes
    mPc = inReset ? '0 : nextPc;
endtask

`endif

//--- tb/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTb import cpuPkg::*; ();
    localparam int PROG_LEN    = 48;
    localparam int INIT_END    = 35;
    localparam int NUM_TESTS   = 9;
    // load, longest run and register read-back of one test
    localparam int TEST_CYCLES = IM_DEPTH + 2 + 4 * IM_DEPTH + 32;
    localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES * 2;
    localparam word_t NOP  = 32'h0000_0000;               // funct 0 is not decoded
    localparam word_t HALT = {C_BEQ, 5'd0, 5'd0, 16'hffff}; // branch to itself

    logic     clk;
    logic     rst;
    logic     imLoadWe;
    word_t    imLoadAddr;
    word_t    imLoadData;
    regAddr_t regAddr;
    word_t    regData;

    integer seed;
    int     cycleCount = 0;
    int     passCount;
    int     failCount;
    int     errCount;
    int     endPc;
    word_t  prog [IM_DEPTH];

    `include "isaModel.svh"

    cpuSystem i_cpuSystem (
        .clk        (clk),
        .rst        (rst),
        .imLoadWe   (imLoadWe),
        .imLoadAddr (imLoadAddr),
        .imLoadData (imLoadData),
        .regAddr    (regAddr),
        .regData    (regData)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    function int rnd(input int n);
        rnd = int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t rType(funct_t f, regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                    logic [4:0] sh);
        return {C_SPEC, rs, rt, rd, sh, f};
    endfunction

    function automatic word_t iType(opcode_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // kind 0..4 R-type, 5 ADDIU, 6 LUI, 7 LW, 8 SW, 9 BEQ, 10 BNE
    function automatic word_t randInstr(int kind, int pos);
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        int       off;
        rs = regAddr_t'(rnd(32));
        rt = regAddr_t'(rnd(32));
        rd = regAddr_t'(rnd(32)); // r0 included on purpose
        case (kind)
            0: return rType(F_ADDU, rs, rt, rd, 5'd0);
            1: return rType(F_SUBU, rs, rt, rd, 5'd0);
            2: return rType(F_OR, rs, rt, rd, 5'd0);
            3: return rType(F_SRL, rs, rt, rd, 5'(rnd(32)));
            4: return rType(F_SLTU, rs, rt, rd, 5'd0);
            5: return iType(C_ADDIU, rs, rt, 16'(rnd(65536)));
            6: return iType(C_LUI, 5'd0, rt, 16'(rnd(65536)));
            7: return iType(C_LW, 5'd0, rt, 16'(rnd(16)));  // few addresses, so hits repeat
            8: return iType(C_SW, 5'd0, rt, 16'(rnd(16)));
            default: begin
                rs  = regAddr_t'(rnd(4));
                rt  = (rnd(3) == 0) ? rs : regAddr_t'(rnd(4));
                off = rnd((PROG_LEN - pos < 5) ? PROG_LEN - pos : 5); // lands at most on halt
                return iType((kind == 9) ? C_BEQ : C_BNE, rs, rt, 16'(off));
            end
        endcase
    endfunction

    task automatic buildRandom(input int lo, input int hi);
        for (int i = 0; i < IM_DEPTH; i++) begin
            if (i < PROG_LEN) prog[i] = randInstr(lo + rnd(hi - lo + 1), i);
            else if (i == PROG_LEN) prog[i] = HALT;
            else prog[i] = NOP;
        end
        endPc = PROG_LEN;
    endtask

    // clears all registers, then a loop stores zero to every data word
    task automatic buildInit();
        for (int i = 0; i < IM_DEPTH; i++) prog[i] = NOP;
        for (int i = 0; i < 31; i++) prog[i] = iType(C_ADDIU, 5'd0, 5'(i + 1), 16'd0);
        prog[31] = iType(C_ADDIU, 5'd0, 5'd2, 16'(DM_DEPTH));
        prog[32] = iType(C_SW, 5'd1, 5'd0, 16'd0);
        prog[33] = iType(C_ADDIU, 5'd1, 5'd1, 16'd1);
        prog[34] = iType(C_BNE, 5'd1, 5'd2, 16'hfffd); // back to the store
        prog[INIT_END] = HALT;
        endPc = INIT_END;
    endtask

    task automatic modelRun(input int resetAt, output int steps);
        mPc = '0;
        if (resetAt > 0) begin
            repeat (resetAt) modelStep(prog[mPc[IM_AW-1:0]], 1'b0);
            repeat (2) modelStep(prog[mPc[IM_AW-1:0]], 1'b1); // two reset edges
        end
        steps = 0;
        while (mPc != word_t'(endPc) && steps < 4 * IM_DEPTH) begin
            modelStep(prog[mPc[IM_AW-1:0]], 1'b0);
            steps++;
        end
    endtask

    // word 0 holds a NOP while reset runs, the real first word goes in last
    task automatic loadProgram();
        int n;
        for (n = 0; n <= IM_DEPTH; n++) begin
            @(posedge clk);
            rst        <= 1'b1;
            imLoadWe   <= 1'b1;
            imLoadAddr <= word_t'(n % IM_DEPTH);
            imLoadData <= (n == 0) ? NOP : prog[n % IM_DEPTH];
        end
        @(posedge clk);
        imLoadWe <= 1'b0;
        rst      <= 1'b0;
    endtask

    task automatic runProgram(input string name, input int resetAt, output int cycles);
        bit done;
        done   = 1'b0;
        cycles = 0;
        if (resetAt > 0) begin
            repeat (resetAt) @(posedge clk);
            rst <= 1'b1;
            repeat (2) @(posedge clk);
            rst <= 1'b0;
            @(negedge clk);
            if (regData != '0) begin
                $display("ERR %s pc after reset expected %h actual %h", name, 32'h0, regData);
                errCount++;
            end
        end
        while (!done) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (regData == word_t'(endPc)) done = 1'b1; // pc parked on the halt word
        end
    endtask

    task automatic checkRegs(input string name);
        int r;
        for (r = 1; r < 32; r++) begin
            @(posedge clk);
            regAddr <= regAddr_t'(r);
            @(negedge clk);
            if (regData != mRegs[r]) begin
                $display("ERR %s r%0d expected %h actual %h", name, r, mRegs[r], regData);
                errCount++;
            end
        end
        @(posedge clk);
        regAddr <= '0;
    endtask

    task automatic doTest(input string name, input int lo, input int hi, input int resetAt,
                          input bit init);
        int expSteps;
        int cycles;
        errCount = 0;
        if (init) buildInit();
        else buildRandom(lo, hi);
        modelRun(resetAt, expSteps);
        loadProgram();
        runProgram(name, resetAt, cycles);
        if (cycles != expSteps) begin
            $display("ERR %s instruction count expected %0d actual %0d", name, expSteps, cycles);
            errCount++;
        end
        checkRegs(name);
        if (errCount == 0) begin
            passCount++;
            $display("%s: ok, %0d instructions", name, cycles);
        end else begin
            failCount++;
            $display("%s: %0d mismatches", name, errCount);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        imLoadWe   = 1'b0;
        imLoadAddr = '0;
        imLoadData = '0;
        regAddr    = '0;
        seed       = 32'habed18d7;
        passCount  = 0;
        failCount  = 0;
        modelClear();
        repeat (2) @(posedge clk);

        doTest("init", 0, 0, 0, 1'b1);
        doTest("immediate", 5, 6, 0, 1'b0);
        doTest("aluReg", 0, 4, 0, 1'b0);
        doTest("loadStore", 5, 8, 0, 1'b0);
        doTest("branch", 5, 10, 0, 1'b0);
        doTest("midReset", 0, 10, 16, 1'b0);
        doTest("mixed1", 0, 10, 0, 1'b0);
        doTest("mixed2", 0, 10, 0, 1'b0);
        doTest("mixed3", 0, 10, 0, 1'b0);

        $display("tests ok %0d, tests with errors %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule

`default_nettype wire
